// File: hw/ddc_macros.svh
`ifndef DDC_MACROS_SVH
`define DDC_MACROS_SVH

// Microprocessor bus geometry
`define BUS_ADDR_WIDTH 12
`define BUS_DATA_WIDTH 32
`define BUS_BYTES 4

// Peer spaces, matched with casez
`define DDC_SPACE 12'h10?
`define CIC_SPACE 12'h11?

// Register map
`define ADDR_CENTER_FREQ 12'h100
`define ADDR_CONTROL 12'h104
`define ADDR_GAIN 12'h108
`define ADDR_CIC_RATE 12'h110

// Base right shift of the gain stage
`define GAIN_SHIFT 45

`endif

// File: hw/ddcPkg.sv
`include "ddc_macros.svh"

package ddcPkg;

    typedef logic signed [17:0] sample_t;
    typedef logic signed [47:0] wideSample_t;
    typedef logic [31:0] freq_t;
    typedef logic [`BUS_ADDR_WIDTH-1:0] busAddr_t;
    typedef logic [`BUS_DATA_WIDTH-1:0] busData_t;

    typedef struct packed {
        logic [4:0] exponent;
        logic [15:0] mantissa;
    } gain_t;

    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_t;

    typedef struct packed {
        wideSample_t i;
        wideSample_t q;
    } wideIq_t;

    typedef struct packed {
        busAddr_t addr;
        busData_t data;
        logic [`BUS_BYTES-1:0] byteWr;
    } busWrite_t;

    localparam sample_t sampleMax = 18'sh1ffff;
    localparam sample_t sampleMin = 18'sh20000;

    // 131071 * cos and sin of 2*pi*k/16
    localparam sample_t loCosTable [16] = '{
        18'sd131071, 18'sd121094, 18'sd92681, 18'sd50159,
        18'sd0, -18'sd50159, -18'sd92681, -18'sd121094,
        -18'sd131071, -18'sd121094, -18'sd92681, -18'sd50159,
        18'sd0, 18'sd50159, 18'sd92681, 18'sd121094
    };
    localparam sample_t loSinTable [16] = '{
        18'sd0, 18'sd50159, 18'sd92681, 18'sd121094,
        18'sd131071, 18'sd121094, 18'sd92681, 18'sd50159,
        18'sd0, -18'sd50159, -18'sd92681, -18'sd121094,
        -18'sd131071, -18'sd121094, -18'sd92681, -18'sd50159
    };

    // Clamp to one 18-bit rail
    function automatic sample_t saturate(input logic signed [63:0] x);
        if (x > sampleMax) begin
            return sampleMax;
        end
        if (x < sampleMin) begin
            return sampleMin;
        end
        return sample_t'(x);
    endfunction

    function automatic busData_t mergeBytes(input busData_t old, input busData_t data,
                                            input logic [`BUS_BYTES-1:0] byteWr);
        busData_t merged;
        merged = old;
        for (int b = 0; b < `BUS_BYTES; b++) begin
            if (byteWr[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: hw/ddcRegs.sv
`timescale 1ns/1ps
`include "ddc_macros.svh"

module ddcRegs (
    input  logic              clk,
    input  logic              reset,
    input  ddcPkg::busWrite_t bus,
    input  logic              cs,
    output ddcPkg::busData_t  rdata,
    output ddcPkg::freq_t     centerFreq,
    output logic              bypassCic,
    output ddcPkg::gain_t     gain
);

    logic wrEn;
    ddcPkg::busData_t controlWord;
    ddcPkg::busData_t gainWord;
    ddcPkg::busData_t freqMerged;
    ddcPkg::busData_t controlMerged;
    ddcPkg::busData_t gainMerged;

    assign wrEn = cs && (bus.byteWr != '0);

    // Unused bits read back as zero
    assign controlWord = {31'b0, bypassCic};
    assign gainWord = {11'b0, gain};

    assign freqMerged = ddcPkg::mergeBytes(centerFreq, bus.data, bus.byteWr);
    assign controlMerged = ddcPkg::mergeBytes(controlWord, bus.data, bus.byteWr);
    assign gainMerged = ddcPkg::mergeBytes(gainWord, bus.data, bus.byteWr);

    always_ff @(posedge clk) begin
        if (reset) begin
            centerFreq <= '0;
            bypassCic <= 1'b0;
            gain <= '0;
        end else if (wrEn) begin
            case (bus.addr)
                `ADDR_CENTER_FREQ: centerFreq <= freqMerged;
                `ADDR_CONTROL: bypassCic <= controlMerged[0];
                `ADDR_GAIN: gain <= gainMerged[$bits(ddcPkg::gain_t)-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (bus.addr)
            `ADDR_CENTER_FREQ: rdata = centerFreq;
            `ADDR_CONTROL: rdata = controlWord;
            `ADDR_GAIN: rdata = gainWord;
            default: rdata = '0;
        endcase
    end

endmodule

// File: hw/loGenerator.sv
`timescale 1ns/1ps

module loGenerator (
    input  logic          clk,
    input  logic          reset,
    input  ddcPkg::freq_t freqOffset,
    input  logic          offsetEn,
    input  ddcPkg::freq_t centerFreq,
    input  logic          syncIn,
    input  ddcPkg::iq_t   sampleIn,
    output ddcPkg::iq_t   lo,
    output ddcPkg::iq_t   sampleOut,
    output logic          strobe
);

    ddcPkg::freq_t offsetHold;
    ddcPkg::freq_t increment;
    ddcPkg::freq_t phase;
    logic [3:0] tableIndex;

    // Coarse 16-point lookup from the top phase bits
    assign tableIndex = phase[31:28];

    always_ff @(posedge clk) begin
        if (reset) begin
            offsetHold <= '0;
            increment <= '0;
            phase <= '0;
            strobe <= 1'b0;
        end else begin
            if (offsetEn) begin
                offsetHold <= freqOffset;
            end
            increment <= offsetHold - centerFreq;
            // Phase moves after the lookup, so the first sample sees phase 0
            if (syncIn) begin
                phase <= phase + increment;
            end
            strobe <= syncIn;
        end
    end

    always_ff @(posedge clk) begin
        if (syncIn) begin
            lo.i <= ddcPkg::loCosTable[tableIndex];
            lo.q <= ddcPkg::loSinTable[tableIndex];
            sampleOut <= sampleIn;
        end
    end

endmodule

// File: hw/complexMixer.sv
`timescale 1ns/1ps

module complexMixer (
    input  logic        clk,
    input  logic        reset,
    input  ddcPkg::iq_t a,
    input  ddcPkg::iq_t b,
    input  logic        strobeIn,
    output ddcPkg::iq_t p,
    output logic        strobeOut
);

    logic signed [35:0] prodII;
    logic signed [35:0] prodQQ;
    logic signed [35:0] prodIQ;
    logic signed [35:0] prodQI;
    logic signed [36:0] sumRe;
    logic signed [36:0] sumIm;
    logic stage1Strobe;

    // Stage one, raw products
    always_ff @(posedge clk) begin
        if (strobeIn) begin
            prodII <= a.i * b.i;
            prodQQ <= a.q * b.q;
            prodIQ <= a.i * b.q;
            prodQI <= a.q * b.i;
        end
    end

    assign sumRe = prodII - prodQQ;
    assign sumIm = prodIQ + prodQI;

    // Stage two, drop 17 fraction bits and clamp
    always_ff @(posedge clk) begin
        if (stage1Strobe) begin
            p.i <= ddcPkg::saturate(sumRe >>> 17);
            p.q <= ddcPkg::saturate(sumIm >>> 17);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage1Strobe <= 1'b0;
            strobeOut <= 1'b0;
        end else begin
            stage1Strobe <= strobeIn;
            strobeOut <= stage1Strobe;
        end
    end

    strobeKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(strobeOut));

endmodule

// File: hw/cicDecimator.sv
`timescale 1ns/1ps
`include "ddc_macros.svh"

module cicDecimator (
    input  logic              clk,
    input  logic              reset,
    input  ddcPkg::busWrite_t bus,
    input  logic              cs,
    output ddcPkg::busData_t  rdata,
    input  ddcPkg::iq_t       in,
    input  logic              strobeIn,
    output ddcPkg::wideIq_t   out,
    output logic              strobeOut
);

    localparam int cicOrder = 3;

    logic [4:0] rate;
    logic [4:0] count;
    logic lastInput;
    logic decimate;
    ddcPkg::busData_t rateWord;
    ddcPkg::busData_t rateMerged;
    ddcPkg::wideSample_t railIn [2];
    ddcPkg::wideSample_t integ [2][cicOrder];
    ddcPkg::wideSample_t integNext [2][cicOrder];
    ddcPkg::wideSample_t combDelay [2][cicOrder];
    ddcPkg::wideSample_t combNext [2][cicOrder];

    assign rateWord = {27'b0, rate};
    assign rateMerged = ddcPkg::mergeBytes(rateWord, bus.data, bus.byteWr);
    assign rdata = (bus.addr == `ADDR_CIC_RATE) ? rateWord : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            rate <= '0;
        end else if (cs && (bus.byteWr != '0) && (bus.addr == `ADDR_CIC_RATE)) begin
            rate <= rateMerged[4:0];
        end
    end

    // Rail 0 is i, rail 1 is q
    assign railIn[0] = in.i;
    assign railIn[1] = in.q;

    // Also catches a count left high by a rate change
    assign lastInput = (count + 5'd1) >= rate;

    always_comb begin
        for (int r = 0; r < 2; r++) begin
            integNext[r][0] = integ[r][0] + railIn[r];
            combNext[r][0] = integ[r][cicOrder-1] - combDelay[r][0];
            for (int s = 1; s < cicOrder; s++) begin
                integNext[r][s] = integ[r][s] + integNext[r][s-1];
                combNext[r][s] = combNext[r][s-1] - combDelay[r][s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            decimate <= 1'b0;
            strobeOut <= 1'b0;
            integ <= '{default: '0};
            combDelay <= '{default: '0};
        end else begin
            if (strobeIn) begin
                count <= lastInput ? 5'd0 : count + 5'd1;
                integ <= integNext;
            end
            decimate <= strobeIn && lastInput;
            strobeOut <= decimate;
            if (decimate) begin
                for (int r = 0; r < 2; r++) begin
                    combDelay[r][0] <= integ[r][cicOrder-1];
                    for (int s = 1; s < cicOrder; s++) begin
                        combDelay[r][s] <= combNext[r][s-1];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decimate) begin
            out.i <= combNext[0][cicOrder-1];
            out.q <= combNext[1][cicOrder-1];
        end
    end

    rateLegal: assert property (@(posedge clk) disable iff (reset)
        strobeIn |-> (rate >= 5'd2 && rate <= 5'd16));

endmodule

// File: hw/variableGain.sv
`timescale 1ns/1ps
`include "ddc_macros.svh"

module variableGain (
    input  logic            clk,
    input  logic            reset,
    input  ddcPkg::wideIq_t in,
    input  logic            strobeIn,
    input  ddcPkg::gain_t   gain,
    output ddcPkg::iq_t     out,
    output logic            strobeOut
);

    logic [5:0] shiftAmt;

    // Exponent reduces the base shift, mantissa 8000h is unity at exponent 0
    assign shiftAmt = 6'(`GAIN_SHIFT) - 6'(gain.exponent);

    function automatic ddcPkg::sample_t scaleRail(input ddcPkg::wideSample_t x,
                                                  input logic [15:0] mantissa,
                                                  input logic [5:0] shift);
        logic signed [63:0] product;
        product = x * $signed({1'b0, mantissa});
        return ddcPkg::saturate(product >>> shift);
    endfunction

    always_ff @(posedge clk) begin
        if (strobeIn) begin
            out.i <= scaleRail(in.i, gain.mantissa, shiftAmt);
            out.q <= scaleRail(in.q, gain.mantissa, shiftAmt);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            strobeOut <= 1'b0;
        end else begin
            strobeOut <= strobeIn;
        end
    end

endmodule

// File: hw/ddcTop.sv
`timescale 1ns/1ps
`include "ddc_macros.svh"

module ddcTop (
    input  logic              clk,
    input  logic              reset,
    input  ddcPkg::busWrite_t bus,
    output ddcPkg::busData_t  dout,
    input  ddcPkg::freq_t     freqOffset,
    input  logic              offsetEn,
    input  logic              syncIn,
    input  ddcPkg::iq_t       sampleIn,
    output logic              syncOut,
    output ddcPkg::iq_t       sampleOut
);

    logic ddcCs;
    logic cicCs;
    ddcPkg::busData_t ddcRdata;
    ddcPkg::busData_t cicRdata;
    ddcPkg::freq_t centerFreq;
    logic bypassCic;
    ddcPkg::gain_t gain;
    ddcPkg::iq_t loValue;
    ddcPkg::iq_t loSample;
    ddcPkg::iq_t mixOut;
    ddcPkg::wideIq_t cicOut;
    ddcPkg::wideIq_t gainIn;
    logic loStrobe;
    logic mixStrobe;
    logic cicStrobeIn;
    logic cicStrobeOut;
    logic gainStrobe;

    // Space decode and read-back mux
    always_comb begin
        ddcCs = 1'b0;
        cicCs = 1'b0;
        dout = '0;
        casez (bus.addr)
            `DDC_SPACE: begin
                ddcCs = 1'b1;
                dout = ddcRdata;
            end
            `CIC_SPACE: begin
                cicCs = 1'b1;
                dout = cicRdata;
            end
            default: ;
        endcase
    end

    ddcRegs regs (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .cs         (ddcCs),
        .rdata      (ddcRdata),
        .centerFreq (centerFreq),
        .bypassCic  (bypassCic),
        .gain       (gain)
    );

    loGenerator loGen (
        .clk        (clk),
        .reset      (reset),
        .freqOffset (freqOffset),
        .offsetEn   (offsetEn),
        .centerFreq (centerFreq),
        .syncIn     (syncIn),
        .sampleIn   (sampleIn),
        .lo         (loValue),
        .sampleOut  (loSample),
        .strobe     (loStrobe)
    );

    complexMixer mixer (
        .clk       (clk),
        .reset     (reset),
        .a         (loSample),
        .b         (loValue),
        .strobeIn  (loStrobe),
        .p         (mixOut),
        .strobeOut (mixStrobe)
    );

    // CIC idles while bypassed
    assign cicStrobeIn = mixStrobe && !bypassCic;

    cicDecimator cic (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .cs        (cicCs),
        .rdata     (cicRdata),
        .in        (mixOut),
        .strobeIn  (cicStrobeIn),
        .out       (cicOut),
        .strobeOut (cicStrobeOut)
    );

    // Bypass lines the mixer output up with the top of the CIC word
    assign gainIn.i = bypassCic ? {mixOut.i, 30'b0} : cicOut.i;
    assign gainIn.q = bypassCic ? {mixOut.q, 30'b0} : cicOut.q;
    assign gainStrobe = bypassCic ? mixStrobe : cicStrobeOut;

    variableGain agc (
        .clk       (clk),
        .reset     (reset),
        .in        (gainIn),
        .strobeIn  (gainStrobe),
        .gain      (gain),
        .out       (sampleOut),
        .strobeOut (syncOut)
    );

endmodule

// File: dv/ddcTb.sv
`timescale 1ns/1ps
`include "ddc_macros.svh"

module ddcTb;

    typedef struct packed {
        ddcPkg::iq_t value;
        logic [63:0] due;
    } expect_t;

    localparam int clkPeriod = 8;
    localparam logic [11:0] regAddr [4] = '{
        `ADDR_CENTER_FREQ, `ADDR_CONTROL, `ADDR_GAIN, `ADDR_CIC_RATE
    };
    localparam logic [31:0] fieldMask [4] = '{32'hffff_ffff, 32'h1, 32'h1f_ffff, 32'h1f};

    logic clk;
    logic reset;
    ddcPkg::busWrite_t bus;
    ddcPkg::busData_t dout;
    ddcPkg::freq_t freqOffset;
    logic offsetEn;
    logic syncIn;
    ddcPkg::iq_t sampleIn;
    logic syncOut;
    ddcPkg::iq_t sampleOut;

    integer seed;
    expect_t expectQ [$];
    expect_t head;
    int outCount;
    int pick;
    int rate;
    int runs;

    // Reference model state with register shadows in address order
    logic [31:0] shadow [4];
    logic [31:0] modelOffset;
    logic [31:0] phase;
    int modelCount;
    longint integ [2][3];
    longint combDelay [2][3];

    ddcTop dut (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .dout       (dout),
        .freqOffset (freqOffset),
        .offsetEn   (offsetEn),
        .syncIn     (syncIn),
        .sampleIn   (sampleIn),
        .syncOut    (syncOut),
        .sampleOut  (sampleOut)
    );

    always #4 clk = ~clk;

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic longint clampRail(input longint v);
        return (v > 131071) ? 131071 : ((v < -131072) ? -131072 : v);
    endfunction

    function automatic longint wrap48(input longint v);
        logic signed [47:0] t;
        t = v[47:0];
        return t;
    endfunction

    function automatic longint gainRail(input longint v);
        longint mant;
        int shift;
        mant = shadow[2][15:0];
        shift = `GAIN_SHIFT - int'(shadow[2][20:16]);
        return clampRail((v * mant) >>> shift);
    endfunction

    task automatic resetModel();
        for (int k = 0; k < 4; k++) begin
            shadow[k] = '0;
        end
        modelOffset = '0;
        phase = '0;
        modelCount = 0;
        for (int r = 0; r < 2; r++) begin
            for (int s = 0; s < 3; s++) begin
                integ[r][s] = 0;
                combDelay[r][s] = 0;
            end
        end
    endtask

    task automatic pushExpected(input longint i, input longint q, input longint due);
        expect_t e;
        e.value.i = i[17:0];
        e.value.q = q[17:0];
        e.due = due;
        expectQ.push_back(e);
    endtask

    task automatic integrate(input int r, input longint v);
        integ[r][0] = wrap48(integ[r][0] + v);
        integ[r][1] = wrap48(integ[r][1] + integ[r][0]);
        integ[r][2] = wrap48(integ[r][2] + integ[r][1]);
    endtask

    // Three combs with differential delay one
    task automatic combDump(input int r, output longint y);
        longint prev;
        y = integ[r][2];
        for (int s = 0; s < 3; s++) begin
            prev = combDelay[r][s];
            combDelay[r][s] = y;
            y = wrap48(y - prev);
        end
    endtask

    task automatic modelSample(input ddcPkg::iq_t s, input longint t);
        ddcPkg::sample_t loI;
        ddcPkg::sample_t loQ;
        longint si;
        longint sq;
        longint mix [2];
        longint y [2];
        loI = ddcPkg::loCosTable[phase[31:28]];
        loQ = ddcPkg::loSinTable[phase[31:28]];
        phase = phase + modelOffset - shadow[0];
        si = s.i;
        sq = s.q;
        mix[0] = clampRail((si * loI - sq * loQ) >>> 17);
        mix[1] = clampRail((si * loQ + sq * loI) >>> 17);
        if (shadow[1][0]) begin
            pushExpected(gainRail(mix[0] <<< 30), gainRail(mix[1] <<< 30),
                         t + 4 * clkPeriod);
        end else begin
            for (int r = 0; r < 2; r++) begin
                integrate(r, mix[r]);
            end
            // Every R-th input dumps the combs
            modelCount++;
            if (modelCount == int'(shadow[3][4:0])) begin
                modelCount = 0;
                for (int r = 0; r < 2; r++) begin
                    combDump(r, y[r]);
                end
                pushExpected(gainRail(y[0]), gainRail(y[1]), t + 6 * clkPeriod);
            end
        end
    endtask

    task automatic writeReg(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
        logic [31:0] bits;
        bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        @(posedge clk);
        bus.addr <= addr;
        bus.data <= data;
        bus.byteWr <= mask;
        for (int k = 0; k < 4; k++) begin
            if (regAddr[k] == addr) begin
                shadow[k] = ((shadow[k] & ~bits) | (data & bits)) & fieldMask[k];
            end
        end
        @(posedge clk);
        bus.byteWr <= '0;
    endtask

    task automatic readCheck(input logic [11:0] addr, input logic [31:0] expected);
        @(posedge clk);
        bus.addr <= addr;
        bus.byteWr <= '0;
        @(negedge clk);
        checkValue(dout, expected, $sformatf("read of address %03h", addr));
    endtask

    // Offset input moves on after the latch pulse
    task automatic latchOffset(input ddcPkg::freq_t value);
        @(posedge clk);
        freqOffset <= value;
        offsetEn <= 1'b1;
        modelOffset = value;
        @(posedge clk);
        offsetEn <= 1'b0;
        freqOffset <= $random(seed);
        repeat (3) @(posedge clk);
    endtask

    task automatic sendSample(input int gap);
        ddcPkg::iq_t s;
        s.i = $random(seed);
        s.q = $random(seed);
        @(posedge clk);
        syncIn <= 1'b1;
        sampleIn <= s;
        modelSample(s, $time);
        repeat (gap) begin
            @(posedge clk);
            syncIn <= 1'b0;
        end
    endtask

    task automatic stopStream();
        @(posedge clk);
        syncIn <= 1'b0;
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (expectQ.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 200) begin
                $display("Timeout at %0t ns: expected output strobe never arrived", $time);
                $display("CHECKS FAILED");
                $fatal(1, "timeout");
            end
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic decimateRun(input int r, input int count);
        outCount = 0;
        for (int k = 0; k < r * count; k++) begin
            sendSample($unsigned($random(seed)) % 4);
        end
        stopStream();
        waitDrain();
        checkValue(outCount, count, $sformatf("outputs for %0d inputs at R %0d", r * count, r));
    endtask

    // Output checker
    always @(negedge clk) begin
        if (!reset && syncOut) begin
            if (expectQ.size() == 0) begin
                $display("Output strobe at %0t ns with no sample in flight", $time);
                $display("CHECKS FAILED");
                $fatal(1, "unexpected syncOut");
            end else begin
                head = expectQ.pop_front();
                checkValue(sampleOut.i, head.value.i, "i rail");
                checkValue(sampleOut.q, head.value.q, "q rail");
                checkValue($time - clkPeriod / 2, head.due, "output strobe time");
                outCount++;
            end
        end
    end

    initial begin
        seed = 32'h4e77_c664;
        clk = 1'b0;
        reset = 1'b1;
        bus = '0;
        freqOffset = '0;
        offsetEn = 1'b0;
        syncIn = 1'b0;
        sampleIn = '0;
        outCount = 0;
        resetModel();
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Register access
        for (int n = 0; n < 40; n++) begin
            pick = $unsigned($random(seed)) % 4;
            writeReg(regAddr[pick], $random(seed), $random(seed));
            readCheck(regAddr[pick], shadow[pick]);
        end
        readCheck(12'h10c, '0);
        readCheck(12'h114, '0);
        readCheck(12'h200, '0);

        // Bypass with a still LO
        writeReg(`ADDR_CONTROL, 32'h1, 4'hf);
        writeReg(`ADDR_GAIN, 32'h8000, 4'hf);
        writeReg(`ADDR_CENTER_FREQ, '0, 4'hf);
        latchOffset('0);
        for (int n = 0; n < 48; n++) begin
            sendSample(0);
        end
        stopStream();
        waitDrain();

        // LO rotation
        for (int n = 0; n < 4; n++) begin
            writeReg(`ADDR_CENTER_FREQ, $random(seed), 4'hf);
            latchOffset($random(seed));
            for (int k = 0; k < 40; k++) begin
                sendSample($unsigned($random(seed)) % 3);
            end
            stopStream();
            waitDrain();
        end

        // Decimation with the rate written before the bypass is cleared
        for (int n = 0; n < 6; n++) begin
            rate = 2 + $unsigned($random(seed)) % 15;
            runs = 3 + $unsigned($random(seed)) % 4;
            writeReg(`ADDR_CIC_RATE, rate, 4'h1);
            writeReg(`ADDR_GAIN, $random(seed), 4'h7);
            writeReg(`ADDR_CONTROL, '0, 4'hf);
            decimateRun(rate, runs);
        end

        // Reset in the middle of a stream
        for (int k = 0; k < 20; k++) begin
            sendSample(0);
        end
        @(posedge clk);
        reset <= 1'b1;
        syncIn <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        expectQ.delete();
        resetModel();
        for (int n = 0; n < 4; n++) begin
            readCheck(regAddr[n], '0);
        end
        repeat (12) @(posedge clk);
        rate = 2 + $unsigned($random(seed)) % 15;
        writeReg(`ADDR_CIC_RATE, rate, 4'hf);
        writeReg(`ADDR_GAIN, 32'h8000, 4'hf);
        writeReg(`ADDR_CENTER_FREQ, $random(seed), 4'hf);
        latchOffset($random(seed));
        decimateRun(rate, 4);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hw
hw/ddcPkg.sv
hw/ddcRegs.sv
hw/loGenerator.sv
hw/complexMixer.sv
hw/cicDecimator.sv
hw/variableGain.sv
hw/ddcTop.sv
dv/ddcTb.sv

// File: Bender.yml
package:
  name: ddc

sources:
  - include_dirs:
      - hw
    files:
      - hw/ddcPkg.sv
      - hw/ddcRegs.sv
      - hw/loGenerator.sv
      - hw/complexMixer.sv
      - hw/cicDecimator.sv
      - hw/variableGain.sv
      - hw/ddcTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/ddcTb.sv
